//--- source/iq_bridge_defs.svh
`ifndef IQ_BRIDGE_DEFS_SVH
`define IQ_BRIDGE_DEFS_SVH

// width of one I or Q component
`define IQ_DATA_WIDTH 16

// fifo address width, 256 locations and 255 usable words
`define IQ_ADDR_WIDTH 8

// credits held by the sender after reset
`define IQ_CREDITS_MAX 8

// credit counter width
`define IQ_CREDIT_WIDTH 4

`endif

//--- source/iq_bridge_pkg.sv
`default_nettype none

`include "iq_bridge_defs.svh"

package iq_bridge_pkg;

  // single I or Q component
  typedef logic [`IQ_DATA_WIDTH-1:0] iq_comp_t;

  // packed pair, I in upper half
  typedef logic [2*`IQ_DATA_WIDTH-1:0] iq_word_t;

  // saturating drop counter
  typedef logic [15:0] ovf_count_t;

endpackage

`default_nettype wire

//--- source/iq_dual_port_ram.sv
`default_nettype none

`include "iq_bridge_defs.svh"

module iq_dual_port_ram
  import iq_bridge_pkg::*;
#(
  parameter int ADDR_WIDTH = `IQ_ADDR_WIDTH
) (
  input  wire logic                  wr_clk_i,
  input  wire logic                  wr_en_i,
  input  wire logic [ADDR_WIDTH-1:0] wr_addr_i,
  input  wire iq_word_t              wr_data_i,
  input  wire logic                  rd_clk_i,
  input  wire logic                  rd_en_i,
  input  wire logic [ADDR_WIDTH-1:0] rd_addr_i,
  output iq_word_t                   rd_data_o
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  iq_word_t mem [DEPTH];

  always_ff @(posedge wr_clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // output register holds until the next read enable
  always_ff @(posedge rd_clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

//--- source/complex_fifo.sv
`default_nettype none

`include "iq_bridge_defs.svh"

module complex_fifo
  import iq_bridge_pkg::*;
#(
  parameter int ADDR_WIDTH = `IQ_ADDR_WIDTH
) (
  input  wire logic     wr_clk_i,
  input  wire logic     wr_rst_i,
  input  wire logic     wr_en_i,
  input  wire iq_word_t wr_data_i,
  output logic          full_o,
  input  wire logic     rd_clk_i,
  input  wire logic     rd_rst_i,
  input  wire logic     rd_en_i,
  output iq_word_t      rd_data_o,
  output logic          empty_o
);

  logic [ADDR_WIDTH-1:0] wr_bin;
  logic [ADDR_WIDTH-1:0] wr_bin_nxt;
  logic [ADDR_WIDTH-1:0] wr_bin_nxt2;
  logic [ADDR_WIDTH-1:0] wr_gray;
  logic [ADDR_WIDTH-1:0] rd_gray_wr_s1;
  logic [ADDR_WIDTH-1:0] rd_gray_wr_s2;
  logic [ADDR_WIDTH-1:0] rd_bin;
  logic [ADDR_WIDTH-1:0] rd_bin_nxt;
  logic [ADDR_WIDTH-1:0] rd_gray;
  logic [ADDR_WIDTH-1:0] wr_gray_rd_s1;
  logic [ADDR_WIDTH-1:0] wr_gray_rd_s2;

  function automatic logic [ADDR_WIDTH-1:0] bin2gray(input logic [ADDR_WIDTH-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  assign wr_bin_nxt  = wr_bin + 1'b1;
  assign wr_bin_nxt2 = wr_bin + 2'd2;
  assign rd_bin_nxt  = rd_bin + 1'b1;

  always_ff @(posedge wr_clk_i) begin
    if (wr_rst_i) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else if (wr_en_i) begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= bin2gray(wr_bin_nxt);
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (wr_rst_i) begin
      rd_gray_wr_s1 <= '0;
      rd_gray_wr_s2 <= '0;
    end else begin
      rd_gray_wr_s1 <= rd_gray; // crosses from rd_clk_i
      rd_gray_wr_s2 <= rd_gray_wr_s1;
    end
  end

  // look one write ahead, one slot always kept free
  always_ff @(posedge wr_clk_i) begin
    if (wr_rst_i)
      full_o <= 1'b0;
    else if (wr_en_i)
      full_o <= (bin2gray(wr_bin_nxt2) == rd_gray_wr_s2);
    else
      full_o <= full_o & (bin2gray(wr_bin_nxt) == rd_gray_wr_s2); // only clears
  end

  always_ff @(posedge rd_clk_i) begin
    if (rd_rst_i) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else if (rd_en_i) begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= bin2gray(rd_bin_nxt);
    end
  end

  always_ff @(posedge rd_clk_i) begin
    if (rd_rst_i) begin
      wr_gray_rd_s1 <= '0;
      wr_gray_rd_s2 <= '0;
    end else begin
      wr_gray_rd_s1 <= wr_gray;
      wr_gray_rd_s2 <= wr_gray_rd_s1;
    end
  end

  always_ff @(posedge rd_clk_i) begin
    if (rd_rst_i)
      empty_o <= 1'b1;
    else if (rd_en_i)
      empty_o <= (bin2gray(rd_bin_nxt) == wr_gray_rd_s2);
    else
      empty_o <= empty_o & (rd_gray == wr_gray_rd_s2); // falls once a write is seen
  end

  iq_dual_port_ram #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_ram (
    .wr_clk_i (wr_clk_i),
    .wr_en_i  (wr_en_i),
    .wr_addr_i(wr_bin),
    .wr_data_i(wr_data_i),
    .rd_clk_i (rd_clk_i),
    .rd_en_i  (rd_en_i),
    .rd_addr_i(rd_bin),
    .rd_data_o(rd_data_o)
  );

endmodule

`default_nettype wire

//--- source/iq_capture.sv
`default_nettype none

module iq_capture
  import iq_bridge_pkg::*;
(
  input  wire logic     wr_clk_i,
  input  wire logic     wr_rst_i,
  input  wire logic     sample_valid_i,
  input  wire iq_comp_t sample_i_i,
  input  wire iq_comp_t sample_q_i,
  input  wire logic     fifo_full_i,
  output logic          fifo_wr_en_o,
  output iq_word_t      fifo_wr_data_o,
  output ovf_count_t    overflow_count_o
);

  logic drop;

  // write straight through, the fifo registers it
  assign fifo_wr_en_o   = sample_valid_i & ~fifo_full_i;
  assign fifo_wr_data_o = {sample_i_i, sample_q_i}; // I on top

  assign drop = sample_valid_i & fifo_full_i;

  // source is never stalled, lost samples are only counted
  always_ff @(posedge wr_clk_i) begin
    if (wr_rst_i) begin
      overflow_count_o <= '0;
    end else if (drop && (overflow_count_o != '1)) begin
      overflow_count_o <= overflow_count_o + 1'b1; // saturates
    end
  end

endmodule

`default_nettype wire

//--- source/iq_credit_sender.sv
`default_nettype none

`include "iq_bridge_defs.svh"

module iq_credit_sender
  import iq_bridge_pkg::*;
(
  input  wire logic     rd_clk_i,
  input  wire logic     rd_rst_i,
  input  wire logic     fifo_empty_i,
  output logic          fifo_rd_en_o,
  input  wire iq_word_t fifo_rd_data_i,
  input  wire logic     credit_return_i,
  output logic          out_valid_o,
  output iq_word_t      out_data_o
);

  localparam logic [`IQ_CREDIT_WIDTH-1:0] CREDITS_MAX = `IQ_CREDIT_WIDTH'(`IQ_CREDITS_MAX);

  logic [`IQ_CREDIT_WIDTH-1:0] credit_cnt;
  logic                        has_credit;

  assign has_credit   = (credit_cnt != '0);
  assign fifo_rd_en_o = has_credit & ~fifo_empty_i; // pop needs data and a credit

  always_ff @(posedge rd_clk_i) begin
    if (rd_rst_i) begin
      credit_cnt <= CREDITS_MAX;
    end else begin
      case ({fifo_rd_en_o, credit_return_i})
        2'b10: begin
          credit_cnt <= credit_cnt - 1'b1;
        end
        2'b01: begin
          credit_cnt <= credit_cnt + 1'b1;
        end
        default: begin
          credit_cnt <= credit_cnt; // pop and return cancel
        end
      endcase
    end
  end

  // ram read data lands one cycle after the pop
  always_ff @(posedge rd_clk_i) begin
    if (rd_rst_i)
      out_valid_o <= 1'b0;
    else
      out_valid_o <= fifo_rd_en_o;
  end

  assign out_data_o = fifo_rd_data_i; // held by ram output reg

endmodule

`default_nettype wire

//--- source/iq_bridge_top.sv
`default_nettype none

`include "iq_bridge_defs.svh"

module iq_bridge_top
  import iq_bridge_pkg::*;
(
  input  wire logic     wr_clk_i,
  input  wire logic     wr_rst_i,
  input  wire logic     sample_valid_i,
  input  wire iq_comp_t sample_i_i,
  input  wire iq_comp_t sample_q_i,
  output ovf_count_t    overflow_count_o,
  input  wire logic     rd_clk_i,
  input  wire logic     rd_rst_i,
  input  wire logic     credit_return_i,
  output logic          out_valid_o,
  output iq_word_t      out_data_o
);

  logic     fifo_wr_en;
  iq_word_t fifo_wr_data;
  logic     fifo_full;
  logic     fifo_rd_en;
  iq_word_t fifo_rd_data;
  logic     fifo_empty;

  iq_capture u_capture (
    .wr_clk_i        (wr_clk_i),
    .wr_rst_i        (wr_rst_i),
    .sample_valid_i  (sample_valid_i),
    .sample_i_i      (sample_i_i),
    .sample_q_i      (sample_q_i),
    .fifo_full_i     (fifo_full),
    .fifo_wr_en_o    (fifo_wr_en),
    .fifo_wr_data_o  (fifo_wr_data),
    .overflow_count_o(overflow_count_o)
  );

  // converter clock to processing clock
  complex_fifo #(
    .ADDR_WIDTH(`IQ_ADDR_WIDTH)
  ) u_fifo (
    .wr_clk_i (wr_clk_i),
    .wr_rst_i (wr_rst_i),
    .wr_en_i  (fifo_wr_en),
    .wr_data_i(fifo_wr_data),
    .full_o   (fifo_full),
    .rd_clk_i (rd_clk_i),
    .rd_rst_i (rd_rst_i),
    .rd_en_i  (fifo_rd_en),
    .rd_data_o(fifo_rd_data),
    .empty_o  (fifo_empty)
  );

  iq_credit_sender u_sender (
    .rd_clk_i       (rd_clk_i),
    .rd_rst_i       (rd_rst_i),
    .fifo_empty_i   (fifo_empty),
    .fifo_rd_en_o   (fifo_rd_en),
    .fifo_rd_data_i (fifo_rd_data),
    .credit_return_i(credit_return_i),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- testbench/iq_bridge_assertions.sv
`default_nettype none

`include "iq_bridge_defs.svh"

module iq_bridge_assertions (
  input wire logic                        rd_clk_i,
  input wire logic                        rd_rst_i,
  input wire logic                        fifo_empty_i,
  input wire logic                        fifo_rd_en_i,
  input wire logic [`IQ_CREDIT_WIDTH-1:0] credit_cnt_i,
  input wire logic                        out_valid_i
);

  int fail_count = 0; // read by the testbench at the end

  credit_bound: assert property (@(posedge rd_clk_i) disable iff (rd_rst_i)
    credit_cnt_i <= `IQ_CREDITS_MAX)
  else begin
    $error("credit count above maximum");
    fail_count++;
  end

  pop_guard: assert property (@(posedge rd_clk_i) disable iff (rd_rst_i)
    fifo_rd_en_i |-> (!fifo_empty_i && credit_cnt_i != '0))
  else begin
    $error("pop while empty or without credit");
    fail_count++;
  end

  valid_follows_pop: assert property (@(posedge rd_clk_i) disable iff (rd_rst_i)
    out_valid_i == $past(fifo_rd_en_i))
  else begin
    $error("out_valid_o does not follow the pop by one cycle");
    fail_count++;
  end

endmodule

bind iq_credit_sender iq_bridge_assertions u_assertions (
  .rd_clk_i    (rd_clk_i),
  .rd_rst_i    (rd_rst_i),
  .fifo_empty_i(fifo_empty_i),
  .fifo_rd_en_i(fifo_rd_en_o),
  .credit_cnt_i(credit_cnt),
  .out_valid_i (out_valid_o)
);

`default_nettype wire

//--- testbench/tb_iq_bridge.sv
`default_nettype none

`include "iq_bridge_defs.svh"

module tb_iq_bridge
  import iq_bridge_pkg::*;
();

  localparam int NUM_TESTS    = 5;
  localparam int QUIET_CYCLES = 20;
  localparam int CAPACITY     = (1 << `IQ_ADDR_WIDTH) - 1;
  localparam int LEFTOVER     = 20 - `IQ_CREDITS_MAX; // left in fifo after credit_limit

  logic       wr_clk;
  logic       rd_clk;
  logic       wr_rst;
  logic       rd_rst;
  logic       sample_valid;
  iq_comp_t   sample_i;
  iq_comp_t   sample_q;
  ovf_count_t overflow_count;
  logic       credit_return;
  logic       out_valid;
  iq_word_t   out_data;

  string test_name [NUM_TESTS];
  int    test_samples [NUM_TESTS];
  bit    test_returns [NUM_TESTS];
  int    test_exp_out [NUM_TESTS];
  int    test_exp_ovf [NUM_TESTS];

  iq_word_t    expected_q [$]; // accepted words in order
  int          error_count;
  int          tests_failed;
  int          cycle_count;
  int          timeout_limit;
  int          test_out;
  int          pending_returns;
  bit          return_en;
  string       cur_name;
  int unsigned seed_ret;

  tb_clock_gen #(.PERIOD(10)) u_wr_clk (.clk_o(wr_clk));
  tb_clock_gen #(.PERIOD(8))  u_rd_clk (.clk_o(rd_clk));

  iq_bridge_top DUT (
    .wr_clk_i        (wr_clk),
    .wr_rst_i        (wr_rst),
    .sample_valid_i  (sample_valid),
    .sample_i_i      (sample_i),
    .sample_q_i      (sample_q),
    .overflow_count_o(overflow_count),
    .rd_clk_i        (rd_clk),
    .rd_rst_i        (rd_rst),
    .credit_return_i (credit_return),
    .out_valid_o     (out_valid),
    .out_data_o      (out_data)
  );

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h actual %h", what, expected, actual);
      error_count++;
    end
  endtask

  task automatic set_row(input int t, input string name, input int samples, input bit returns,
                         input int exp_out, input int exp_ovf);
    test_name[t]    = name;
    test_samples[t] = samples;
    test_returns[t] = returns;
    test_exp_out[t] = exp_out;
    test_exp_ovf[t] = exp_ovf;
  endtask

  task automatic drive_samples(input int count);
    for (int n = 0; n < count; n++) begin
      @(posedge wr_clk);
      #1;
      sample_i     = iq_comp_t'($urandom);
      sample_q     = iq_comp_t'($urandom);
      sample_valid = 1'b1;
      if (!DUT.fifo_full) begin // full holds until the next edge
        expected_q.push_back({sample_i, sample_q});
      end
    end
    @(posedge wr_clk);
    #1;
    sample_valid = 1'b0;
  endtask

  task automatic run_test(input int t);
    int         errs_before;
    ovf_count_t ovf_before;
    ovf_count_t ovf_delta;
    errs_before = error_count;
    ovf_before  = overflow_count;
    cur_name    = test_name[t];
    return_en   = test_returns[t];
    test_out    = 0;
    drive_samples(test_samples[t]);
    while (test_out < test_exp_out[t]) @(posedge rd_clk);
    repeat (QUIET_CYCLES) @(posedge rd_clk); // no extra words allowed
    ovf_delta = overflow_count - ovf_before;
    check_value({cur_name, " output count"}, test_exp_out[t], test_out);
    check_value({cur_name, " overflow"}, test_exp_ovf[t], ovf_delta);
    if (error_count == errs_before) begin
      $display("test %s: pass, %0d words out, %0d dropped", cur_name, test_out, ovf_delta);
    end else begin
      tests_failed++;
      $display("test %s: fail", cur_name);
    end
  endtask

  // one credit back per word seen, a cycle later
  always @(posedge rd_clk) begin
    #1;
    if (return_en && pending_returns > 0) begin
      credit_return = 1'b1;
      pending_returns--;
    end else begin
      credit_return = 1'b0;
    end
  end

  always @(negedge rd_clk) begin
    if (out_valid === 1'b1) begin
      test_out++;
      pending_returns++;
      if (expected_q.size() == 0) begin
        $display("error in %s: output word %h with no accepted sample", cur_name, out_data);
        error_count++;
      end else begin
        check_value({cur_name, " data"}, expected_q.pop_front(), out_data);
      end
    end
  end

  always @(posedge rd_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: run did not finish within %0d read clock cycles", timeout_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    seed_ret        = $urandom(17);
    sample_valid    = 1'b0;
    sample_i        = '0;
    sample_q        = '0;
    credit_return   = 1'b0;
    wr_rst          = 1'b1;
    rd_rst          = 1'b1;
    return_en       = 1'b0;
    pending_returns = 0;
    error_count     = 0;
    tests_failed    = 0;
    cycle_count     = 0;
    test_out        = 0;
    cur_name        = "reset";
    set_row(0, "reset_idle", 0, 1'b1, 0, 0);
    set_row(1, "ordered_transfer", 40, 1'b1, 40, 0);
    set_row(2, "credit_limit", 20, 1'b0, `IQ_CREDITS_MAX, 0);
    set_row(3, "overflow", 300, 1'b0, 0, 300 - (CAPACITY - LEFTOVER)); // no credit left
    set_row(4, "resume", 0, 1'b1, CAPACITY, 0);
    timeout_limit = 200;
    for (int t = 0; t < NUM_TESTS; t++) begin
      timeout_limit += 4 * test_samples[t];
    end
    fork
      begin
        repeat (10) @(posedge rd_clk);
        #1;
        rd_rst = 1'b0;
      end
      begin
        repeat (10) @(posedge wr_clk);
        #1;
        wr_rst = 1'b0;
      end
    join
    @(posedge rd_clk);
    check_value("reset overflow count", 0, overflow_count);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    check_value("words left undelivered", 0, expected_q.size());
    if (DUT.u_sender.u_assertions.fail_count != 0) begin
      $display("%0d assertion failures seen", DUT.u_sender.u_assertions.fail_count);
      error_count += DUT.u_sender.u_assertions.fail_count;
    end
    $display("tests passed: %0d, failed: %0d, errors: %0d",
             NUM_TESTS - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- iq_bridge.f
+incdir+source
source/iq_bridge_pkg.sv
source/iq_dual_port_ram.sv
source/complex_fifo.sv
source/iq_capture.sv
source/iq_credit_sender.sv
source/iq_bridge_top.sv
testbench/tb_clock_gen.sv
testbench/iq_bridge_assertions.sv
testbench/tb_iq_bridge.sv
